/* source/core_settings.svh */
// core settings
// widths and reset values shared by every block of the register-only MIPS32 core

`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data path and instruction word width
`define CORE_DATA_W 32

// architectural registers, register 0 included
`define CORE_REG_COUNT 32

// byte address of the first instruction fetch
`define CORE_RESET_PC 32'h0000_0000

`endif

/* source/core_pkg.sv */
// core package
// operation codes and the two views of a MIPS32 instruction word

`default_nettype none

package core_pkg;

    // one value per supported operation
    typedef enum logic [4:0] {
        op_invalid,
        op_add,
        op_addu,
        op_sub,
        op_subu,
        op_and,
        op_or,
        op_xor,
        op_nor,
        op_slt,
        op_sltu,
        op_sll,
        op_srl,
        op_sra,
        op_sllv,
        op_srlv,
        op_srav,
        op_lui,
        op_ori
    } op_e;

    // R-format fields of the SPECIAL opcode
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    // I-format fields of LUI and ORI
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // decode looks at the same word through both formats
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_word_u;

endpackage

`default_nettype wire

/* source/stage_if.sv */
// decode to execute bundle
// one decoded operation per cycle, plus the execute result read back for forwarding

`default_nettype none

`include "core_settings.svh"

interface stage_if import core_pkg::*; ();

    logic                    valid;
    op_e                     op;
    logic [4:0]              rd;
    logic [`CORE_DATA_W-1:0] opa;
    logic [`CORE_DATA_W-1:0] opb;
    logic [4:0]              shamt;
    logic                    wen;

    // combinational result of the operation now in execute
    logic [`CORE_DATA_W-1:0] res;

    modport src (output valid, op, rd, opa, opb, shamt, wen);

    modport dst (input valid, op, rd, opa, opb, shamt, wen, output res);

endinterface

`default_nettype wire

/* source/fetch_wb.sv */
// instruction fetch stage
// Wishbone classic read master with program counter, hands each word to decode

`default_nettype none

`include "core_settings.svh"

module fetch_wb import core_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,

    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output logic [`CORE_DATA_W-1:0] wb_adr,
    input  logic [`CORE_DATA_W-1:0] wb_dat_i,
    input  logic                    wb_ack,

    output logic                    f_valid,
    output instr_word_u             f_word,
    output logic [`CORE_DATA_W-1:0] f_pc
);

    logic                    req;
    logic [`CORE_DATA_W-1:0] pc;
    logic                    accept;

    // a transfer completes when ack is seen while the request is up
    assign accept = req && wb_ack;

    assign wb_cyc = req;
    assign wb_stb = req;
    assign wb_we  = 1'b0;
    assign wb_adr = pc;

    // request drops for one cycle out of reset, then stays up
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            req     <= 1'b0;
            pc      <= `CORE_RESET_PC;
            f_valid <= 1'b0;
        end
        else
        begin
            req     <= 1'b1;
            f_valid <= accept;
            if (accept)
                pc <= pc + `CORE_DATA_W'd4;
        end
    end

    // word and its address, held for decode
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            f_word <= wb_dat_i;
            f_pc   <= pc;
        end
    end

endmodule

`default_nettype wire

/* source/reg_file.sv */
// register file
// 32 general registers, two combinational reads, one write, register 0 reads zero

`default_nettype none

`include "core_settings.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [4:0]              raddr_a,
    input  logic [4:0]              raddr_b,
    output logic [`CORE_DATA_W-1:0] rdata_a,
    output logic [`CORE_DATA_W-1:0] rdata_b,
    input  logic                    we,
    input  logic [4:0]              waddr,
    input  logic [`CORE_DATA_W-1:0] wdata
);

    // register 0 has no storage behind it
    logic [`CORE_DATA_W-1:0] regs [1:`CORE_REG_COUNT-1];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 1; i < `CORE_REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (we && (waddr != 5'd0))
            regs[waddr] <= wdata;
    end

    assign rdata_a = (raddr_a == 5'd0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == 5'd0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

/* source/decode_stage.sv */
// decode stage
// maps SPECIAL R-type words and LUI/ORI to operations, reads and forwards operands

`default_nettype none

`include "core_settings.svh"

module decode_stage import core_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    f_valid,
    input  instr_word_u             f_word,
    input  logic [`CORE_DATA_W-1:0] f_pc,
    output logic [4:0]              raddr_a,
    output logic [4:0]              raddr_b,
    input  logic [`CORE_DATA_W-1:0] rdata_a,
    input  logic [`CORE_DATA_W-1:0] rdata_b,
    stage_if.src                    ex,
    stage_if.dst                    ex_fwd,
    output logic [`CORE_DATA_W-1:0] d_pc
);

    op_e                     op_d;
    logic [4:0]              rd_d;
    logic                    use_imm;
    logic [`CORE_DATA_W-1:0] imm_val;
    logic                    hit_a;
    logic                    hit_b;
    logic [`CORE_DATA_W-1:0] rs_val;
    logic [`CORE_DATA_W-1:0] rt_val;

    // rs and rt sit in the same bits in both formats
    assign raddr_a = f_word.r.rs;
    assign raddr_b = f_word.r.rt;

    // ############################################################
    // operation decode
    // ############################################################
    always_comb
    begin
        op_d    = op_invalid;
        rd_d    = f_word.r.rd;
        use_imm = 1'b0;
        imm_val = '0;
        case (f_word.r.opcode)
            6'h00:
            begin
                case (f_word.r.funct)
                    6'h00: op_d = op_sll;
                    6'h02: op_d = op_srl;
                    6'h03: op_d = op_sra;
                    6'h04: op_d = op_sllv;
                    6'h06: op_d = op_srlv;
                    6'h07: op_d = op_srav;
                    6'h20: op_d = op_add;
                    6'h21: op_d = op_addu;
                    6'h22: op_d = op_sub;
                    6'h23: op_d = op_subu;
                    6'h24: op_d = op_and;
                    6'h25: op_d = op_or;
                    6'h26: op_d = op_xor;
                    6'h27: op_d = op_nor;
                    6'h2a: op_d = op_slt;
                    6'h2b: op_d = op_sltu;
                    default: op_d = op_invalid;
                endcase
            end
            6'h0f:
            begin
                op_d    = op_lui;
                rd_d    = f_word.i.rt;
                use_imm = 1'b1;
                imm_val = {f_word.i.imm, 16'h0000};
            end
            6'h0d:
            begin
                op_d    = op_ori;
                rd_d    = f_word.i.rt;
                use_imm = 1'b1;
                imm_val = {16'h0000, f_word.i.imm};
            end
            default: op_d = op_invalid;
        endcase
    end

    // ############################################################
    // operand select with bypass from execute
    // ############################################################
    // wen is already low for register 0, so r0 is never bypassed
    assign hit_a = ex_fwd.valid && ex_fwd.wen && (ex_fwd.rd == raddr_a);
    assign hit_b = ex_fwd.valid && ex_fwd.wen && (ex_fwd.rd == raddr_b);

    assign rs_val = hit_a ? ex_fwd.res : rdata_a;
    assign rt_val = hit_b ? ex_fwd.res : rdata_b;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ex.valid <= 1'b0;
        else
            ex.valid <= f_valid;
    end

    always_ff @(posedge clk)
    begin
        if (f_valid)
        begin
            ex.op    <= op_d;
            ex.rd    <= rd_d;
            ex.opa   <= rs_val;
            ex.opb   <= use_imm ? imm_val : rt_val;
            ex.shamt <= f_word.r.shamt;
            ex.wen   <= (op_d != op_invalid) && (rd_d != 5'd0);
            d_pc     <= f_pc;
        end
    end

endmodule

`default_nettype wire

/* source/execute_stage.sv */
// execute stage
// ALU and shifter, register write-back and the retirement report

`default_nettype none

`include "core_settings.svh"

module execute_stage import core_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    stage_if.dst                    ex,
    input  logic [`CORE_DATA_W-1:0] d_pc,
    output logic                    we,
    output logic [4:0]              waddr,
    output logic [`CORE_DATA_W-1:0] wdata,
    output logic                    retire_valid,
    output logic                    retire_invalid,
    output logic [4:0]              retire_reg,
    output logic [`CORE_DATA_W-1:0] retire_data,
    output logic [`CORE_DATA_W-1:0] retire_pc
);

    logic [`CORE_DATA_W-1:0] result;

    always_comb
    begin
        case (ex.op)
            op_add, op_addu: result = ex.opa + ex.opb;
            op_sub, op_subu: result = ex.opa - ex.opb;
            op_and:          result = ex.opa & ex.opb;
            op_or, op_ori:   result = ex.opa | ex.opb;
            op_xor:          result = ex.opa ^ ex.opb;
            op_nor:          result = ~(ex.opa | ex.opb);
            op_slt:          result = {{(`CORE_DATA_W-1){1'b0}}, $signed(ex.opa) < $signed(ex.opb)};
            op_sltu:         result = {{(`CORE_DATA_W-1){1'b0}}, ex.opa < ex.opb};
            op_sll:          result = ex.opb << ex.shamt;
            op_srl:          result = ex.opb >> ex.shamt;
            op_sra:          result = $signed(ex.opb) >>> ex.shamt;
            // variable shifts take the amount from the low bits of rs
            op_sllv:         result = ex.opb << ex.opa[4:0];
            op_srlv:         result = ex.opb >> ex.opa[4:0];
            op_srav:         result = $signed(ex.opb) >>> ex.opa[4:0];
            op_lui:          result = ex.opb;
            default:         result = '0;
        endcase
    end

    // decode picks this up for an operation that needs it next cycle
    assign ex.res = result;

    // the register file takes the result at the same edge the report is loaded
    assign we    = ex.valid && ex.wen;
    assign waddr = ex.rd;
    assign wdata = result;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            retire_valid   <= 1'b0;
            retire_invalid <= 1'b0;
        end
        else
        begin
            retire_valid   <= ex.valid;
            retire_invalid <= ex.valid && (ex.op == op_invalid);
        end
    end

    always_ff @(posedge clk)
    begin
        if (ex.valid)
        begin
            retire_reg  <= ex.rd;
            retire_data <= result;
            retire_pc   <= d_pc;
        end
    end

endmodule

`default_nettype wire

/* source/mips_rcore.sv */
// register-only MIPS32 core
// fetch over Wishbone, decode, execute and retire, three stages in order

`default_nettype none

`include "core_settings.svh"

module mips_rcore import core_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output logic [`CORE_DATA_W-1:0] wb_adr,
    input  logic [`CORE_DATA_W-1:0] wb_dat_i,
    input  logic                    wb_ack,
    output logic                    retire_valid,
    output logic                    retire_invalid,
    output logic [4:0]              retire_reg,
    output logic [`CORE_DATA_W-1:0] retire_data,
    output logic [`CORE_DATA_W-1:0] retire_pc
);

    logic                    f_valid;
    instr_word_u             f_word;
    logic [`CORE_DATA_W-1:0] f_pc;
    logic [`CORE_DATA_W-1:0] d_pc;
    logic [4:0]              raddr_a;
    logic [4:0]              raddr_b;
    logic [`CORE_DATA_W-1:0] rdata_a;
    logic [`CORE_DATA_W-1:0] rdata_b;
    logic                    we;
    logic [4:0]              waddr;
    logic [`CORE_DATA_W-1:0] wdata;

    stage_if i_stage_if ();

    // ############################################################
    // stages
    // ############################################################
    fetch_wb i_fetch_wb (
        .clk(clk), .rst_n(rst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
        .f_valid(f_valid), .f_word(f_word), .f_pc(f_pc)
    );

    decode_stage i_decode_stage (
        .clk(clk), .rst_n(rst_n),
        .f_valid(f_valid), .f_word(f_word), .f_pc(f_pc),
        .raddr_a(raddr_a), .raddr_b(raddr_b),
        .rdata_a(rdata_a), .rdata_b(rdata_b),
        .ex(i_stage_if.src), .ex_fwd(i_stage_if.dst),
        .d_pc(d_pc)
    );

    execute_stage i_execute_stage (
        .clk(clk), .rst_n(rst_n),
        .ex(i_stage_if.dst), .d_pc(d_pc),
        .we(we), .waddr(waddr), .wdata(wdata),
        .retire_valid(retire_valid), .retire_invalid(retire_invalid),
        .retire_reg(retire_reg), .retire_data(retire_data), .retire_pc(retire_pc)
    );

    reg_file i_reg_file (
        .clk(clk), .rst_n(rst_n),
        .raddr_a(raddr_a), .raddr_b(raddr_b),
        .rdata_a(rdata_a), .rdata_b(rdata_b),
        .we(we), .waddr(waddr), .wdata(wdata)
    );

endmodule

`default_nettype wire

/* testbench/tb_mips_rcore.sv */
// testbench for the register-only MIPS32 core
// random program served by a Wishbone slave model, retirements checked against a model

`default_nettype none

`include "core_settings.svh"

module tb_mips_rcore;

    localparam int PROG_LEN = 200;
    localparam logic [5:0] R_FUNCTS [16] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25,
        6'h26, 6'h27, 6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07};

    logic        clk = 1'b0;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_i;
    logic        wb_ack;
    logic        retire_valid;
    logic        retire_invalid;
    logic [4:0]  retire_reg;
    logic [31:0] retire_data;
    logic [31:0] retire_pc;

    logic [31:0] lcg_state;
    logic [31:0] prog [PROG_LEN];
    logic [31:0] model_regs [32];
    int          ack_edges [$];
    int          edge_cnt = 0;
    int          fetch_count = 0;
    int          wait_left = 0;
    int          retired = 0;
    int          pass_count [6];
    int          fail_count [6];
    int          other_errors = 0;
    int          total_fail;

    mips_rcore i_mips_rcore (
        .clk(clk), .rst_n(rst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
        .retire_valid(retire_valid), .retire_invalid(retire_invalid),
        .retire_reg(retire_reg), .retire_data(retire_data), .retire_pc(retire_pc)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
        edge_cnt <= edge_cnt + 1;

    // ############################################################
    // helpers
    // ############################################################
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // the low LCG bits are weak, so draw from the upper ones
    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[31:8] % 24'(n));
    endfunction

    function automatic string test_name(input int c);
        case (c)
            0: return "fetch addresses";
            1: return "lui and ori";
            2: return "alu and compares";
            3: return "shifts";
            4: return "invalid words and register 0";
            default: return "order and latency";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, input int cat);
        if (expected !== actual)
        begin
            $display("[FAIL] %s expected %h actual %h at %0t", name, expected, actual, $time);
            fail_count[cat]++;
        end
        else
            pass_count[cat]++;
    endtask

    task automatic build_program();
        int          i;
        int          kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        i = 0;
        while (i < PROG_LEN)
        begin
            kind = rand_below(6);
            // only eight registers, so operations depend on each other often
            rs   = 5'(rand_below(8));
            rt   = 5'(rand_below(8));
            rd   = 5'(rand_below(8));
            imm  = 16'(rand_below(65536));
            if (kind == 0 && i + 1 < PROG_LEN)
            begin
                // the ori right after its lui only sees the value through the bypass
                prog[i]     = {6'h0f, 5'd0, rt, imm};
                prog[i + 1] = {6'h0d, rt, rt, 16'(rand_below(65536))};
                i = i + 1;
            end
            else if (kind == 1)
                prog[i] = {6'h0d, rs, rt, imm};
            else if (kind < 5)
                prog[i] = {6'h00, rs, rt, rd, 5'(rand_below(32)), R_FUNCTS[rand_below(16)]};
            else
            begin
                prog[i] = lcg_next();
                if (prog[i][31:26] == 6'h0d || prog[i][31:26] == 6'h0f)
                    prog[i][31:26] = 6'h3f;
                else if (prog[i][31:26] == 6'h00)
                    prog[i][5:0] = 6'h18;
            end
            i = i + 1;
        end
    endtask

    // ############################################################
    // reference model of one instruction
    // ############################################################
    task automatic model_step(input logic [31:0] w, output logic ok, output logic [4:0] dst,
                              output logic [31:0] val, output int cat);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  amt;
        a   = model_regs[w[25:21]];
        b   = model_regs[w[20:16]];
        // variable shifts have funct bit 2 set and take the amount from rs
        amt = w[2] ? a[4:0] : w[10:6];
        ok  = 1'b1;
        dst = w[15:11];
        val = '0;
        cat = 2;
        if (w[31:26] == 6'h0f || w[31:26] == 6'h0d)
        begin
            dst = w[20:16];
            cat = 1;
            val = (w[31:26] == 6'h0f) ? {w[15:0], 16'h0000} : (a | {16'h0000, w[15:0]});
        end
        else if (w[31:26] != 6'h00)
            ok = 1'b0;
        else
        begin
            case (w[5:0])
                6'h20, 6'h21: val = a + b;
                6'h22, 6'h23: val = a - b;
                6'h24: val = a & b;
                6'h25: val = a | b;
                6'h26: val = a ^ b;
                6'h27: val = ~(a | b);
                6'h2a: val = {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
                6'h2b: val = {31'b0, a < b};
                6'h00, 6'h04: val = b << amt;
                6'h02, 6'h06: val = b >> amt;
                6'h03, 6'h07: val = (b >> amt) | (b[31] ? ~(32'hffff_ffff >> amt) : 32'h0);
                default: ok = 1'b0;
            endcase
            if (w[5:3] == 3'b000)
                cat = 3;
        end
        if (!ok || dst == 5'd0)
            cat = 4;
    endtask

    task automatic check_retirement();
        logic        ok;
        logic [4:0]  dst;
        logic [31:0] val;
        int          cat;
        if (retired >= PROG_LEN)
        begin
            $display("error: a retirement came after the last instruction of the program");
            other_errors++;
        end
        else
        begin
            model_step(prog[retired], ok, dst, val, cat);
            check_value("retire_pc", `CORE_RESET_PC + 32'(retired * 4), retire_pc, 5);
            if (ack_edges.size() == 0)
            begin
                $display("error: retirement %0d has no acknowledged fetch behind it", retired);
                other_errors++;
            end
            else
                check_value("retire edge", 32'(ack_edges.pop_front() + 2), 32'(edge_cnt), 5);
            check_value("retire_invalid", {31'b0, !ok}, {31'b0, retire_invalid}, cat);
            if (ok)
            begin
                check_value("retire_reg", {27'b0, dst}, {27'b0, retire_reg}, cat);
                check_value("retire_data", val, retire_data, cat);
                if (dst != 5'd0)
                    model_regs[dst] = val;
            end
            retired++;
        end
    endtask

    // ############################################################
    // Wishbone slave and retirement monitor
    // ############################################################
    always @(negedge clk)
    begin
        if (!rst_n)
            wb_ack = 1'b0;
        else
        begin
            // ack high here means the rising edge just passed took the word
            if (wb_ack)
            begin
                fetch_count++;
                wait_left = rand_below(4);
            end
            wb_ack = 1'b0;
            if (wb_cyc || edge_cnt > 8)
            begin
                check_value("wb_stb", 32'd1, {31'b0, wb_stb}, 0);
                check_value("wb_cyc", 32'd1, {31'b0, wb_cyc}, 0);
                check_value("wb_we", 32'd0, {31'b0, wb_we}, 0);
                check_value("wb_adr", `CORE_RESET_PC + 32'(fetch_count * 4), wb_adr, 0);
                if (fetch_count < PROG_LEN && wait_left == 0)
                begin
                    wb_ack   = 1'b1;
                    wb_dat_i = prog[fetch_count];
                    ack_edges.push_back(edge_cnt + 1);
                end
                else if (wait_left > 0)
                    wait_left--;
            end
        end
    end

    always @(negedge clk)
    begin
        if (rst_n && retire_valid)
            check_retirement();
    end

    // sized for the slowest fetch plus pipeline fill
    initial
    begin
        #((PROG_LEN * 8 + 100) * 8);
        $display("watchdog: retirements stopped after %0d of %0d", retired, PROG_LEN);
        $display("TESTS FAILED");
        $finish;
    end

    // ############################################################
    // main sequence
    // ############################################################
    initial
    begin
        rst_n     = 1'b0;
        wb_ack    = 1'b0;
        wb_dat_i  = '0;
        lcg_state = 32'h935d_764f;
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        for (int c = 0; c < 6; c++)
        begin
            pass_count[c] = 0;
            fail_count[c] = 0;
        end
        build_program();
        wait_left = rand_below(4);
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("wb_cyc", 32'd0, {31'b0, wb_cyc}, 0);
        check_value("retire_valid", 32'd0, {31'b0, retire_valid}, 5);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("wb_cyc", 32'd1, {31'b0, wb_cyc}, 0);
        wait (retired == PROG_LEN);
        // a few more cycles so that a stray extra retirement is still seen
        repeat (4) @(negedge clk);

        total_fail = other_errors;
        for (int c = 0; c < 6; c++)
        begin
            if (pass_count[c] + fail_count[c] == 0)
            begin
                $display("test %s was never exercised", test_name(c));
                total_fail++;
            end
            else
                $display("test %s: %0d checks, %0d failed", test_name(c),
                         pass_count[c] + fail_count[c], fail_count[c]);
            total_fail += fail_count[c];
        end
        $display("checks passed %0d, failed %0d", pass_count.sum(), total_fail);
        if (total_fail == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+source
source/core_pkg.sv
source/stage_if.sv
source/fetch_wb.sv
source/reg_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/mips_rcore.sv
testbench/tb_mips_rcore.sv

/* Makefile */
TOP = tb_mips_rcore

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f vlog.f --top-module $(TOP) -Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
